//--- design/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit #(
    parameter int memWaitCycles = 2
) (
    input  logic              clk,
    input  logic              arstN,
    input  isaPkg::opcodeT    opcode,
    input  isaPkg::functT     funct,
    output logic              pcWrite,
    output logic              pcWriteCond,
    output ctrlPkg::pcSourceT pcSource,
    output logic              iorD,
    output logic              memWrite,
    output logic              irWrite,
    output logic              aluSrcA,
    output ctrlPkg::aluSrcBT  aluSrcB,
    output ctrlPkg::aluOpT    aluOp,
    output ctrlPkg::shiftSrcT shiftSrc,
    output ctrlPkg::shiftOpT  shiftOp,
    output ctrlPkg::regDestT  regDest,
    output ctrlPkg::memToRegT memToReg,
    output logic              regWrite,
    output logic              illegalOp
);

    ctrlPkg::stateT    state;
    ctrlPkg::ctrlWordT ctrlWord;

    decodeIf dec (.clk(clk));

    instrDecoder uDecoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (dec.decoder)
    );

    stepSequencer #(
        .memWaitCycles (memWaitCycles)
    ) uSequencer (
        .clk   (clk),
        .arstN (arstN),
        .dec   (dec.sequencer),
        .state (state)
    );

    controlWordGen uWordGen (
        .state (state),
        .dec   (dec.wordGen),
        .ctrl  (ctrlWord)
    );

    assign pcWrite     = ctrlWord.pcWrite;
    assign pcWriteCond = ctrlWord.pcWriteCond;
    assign pcSource    = ctrlWord.pcSource;
    assign iorD        = ctrlWord.iorD;
    assign memWrite    = ctrlWord.memWrite;
    assign irWrite     = ctrlWord.irWrite;
    assign aluSrcA     = ctrlWord.aluSrcA;
    assign aluSrcB     = ctrlWord.aluSrcB;
    assign aluOp       = ctrlWord.aluOp;
    assign shiftSrc    = ctrlWord.shiftSrc;
    assign shiftOp     = ctrlWord.shiftOp;
    assign regDest     = ctrlWord.regDest;
    assign memToReg    = ctrlWord.memToReg;
    assign regWrite    = ctrlWord.regWrite;

    assign illegalOp = (state == ctrlPkg::stDecode) && dec.illegal; // flagged in decode only

endmodule

`default_nettype wire

//--- design/controlWordGen.sv
`timescale 1ns/1ps
`default_nettype none

module controlWordGen (
    input  ctrlPkg::stateT    state,
    decodeIf.wordGen          dec,
    output ctrlPkg::ctrlWordT ctrl
);

    always_comb
    begin
        ctrl = '0;
        case (state)
            ctrlPkg::stIdle: ctrl = '0; // all writes off
            ctrlPkg::stFetch:
            begin
                ctrl.iorD     = 1'b0;
                ctrl.irWrite  = 1'b1;
                ctrl.aluSrcA  = 1'b0;
                ctrl.aluSrcB  = ctrlPkg::srcBFour; // pc + 4
                ctrl.aluOp    = ctrlPkg::aluAdd;
                ctrl.pcWrite  = 1'b1;
                ctrl.pcSource = ctrlPkg::pcAluResult;
            end
            ctrlPkg::stDecode:
            begin
                ctrl.aluSrcA = 1'b0;
                ctrl.aluSrcB = ctrlPkg::srcBBranchOffset; // target into aluOut
                ctrl.aluOp   = ctrlPkg::aluAdd;
            end
            ctrlPkg::stShiftLoad:
            begin
                ctrl.shiftSrc = dec.shiftSrc;
                ctrl.shiftOp  = dec.shiftOp;
            end
            ctrlPkg::stExec:
            begin
                case (dec.instrClass)
                    isaPkg::clsAlu:
                    begin
                        ctrl.aluSrcA = 1'b1;
                        if (dec.useImm)
                        begin
                            ctrl.aluSrcB = ctrlPkg::srcBImm;
                        end
                        else
                        begin
                            ctrl.aluSrcB = ctrlPkg::srcBReg;
                        end
                        ctrl.aluOp = dec.aluOp;
                    end
                    isaPkg::clsShift:
                    begin
                        ctrl.shiftSrc = dec.shiftSrc;
                        ctrl.shiftOp  = dec.shiftOp;
                    end
                    isaPkg::clsBranch:
                    begin
                        ctrl.aluSrcA     = 1'b1;
                        ctrl.aluSrcB     = ctrlPkg::srcBReg;
                        ctrl.aluOp       = dec.aluOp; // compare code
                        ctrl.pcWriteCond = 1'b1;
                        ctrl.pcSource    = ctrlPkg::pcAluOut;
                    end
                    isaPkg::clsJump:
                    begin
                        ctrl.pcWrite  = 1'b1;
                        ctrl.pcSource = ctrlPkg::pcJumpTarget;
                        if (dec.link)
                        begin
                            ctrl.regWrite = 1'b1;
                            ctrl.regDest  = ctrlPkg::dstRa;
                            ctrl.memToReg = ctrlPkg::wbPcLink;
                        end
                    end
                    isaPkg::clsLoad, isaPkg::clsStore:
                    begin
                        ctrl.aluSrcA = 1'b1;
                        ctrl.aluSrcB = ctrlPkg::srcBImm; // base + offset
                        ctrl.aluOp   = ctrlPkg::aluAdd;
                    end
                    default: ctrl = '0;
                endcase
            end
            ctrlPkg::stMemWait:
            begin
                ctrl.iorD = 1'b1;
            end
            ctrlPkg::stMemWrite:
            begin
                ctrl.iorD     = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            ctrlPkg::stWriteback:
            begin
                ctrl.regWrite = 1'b1;
                ctrl.regDest  = ctrlPkg::dstRt;
                if (!dec.useImm && dec.instrClass != isaPkg::clsLoad)
                begin
                    ctrl.regDest = ctrlPkg::dstRd; // r-type
                end
                case (dec.instrClass)
                    isaPkg::clsShift: ctrl.memToReg = ctrlPkg::wbShift;
                    isaPkg::clsLoad:  ctrl.memToReg = ctrlPkg::wbMem;
                    default:          ctrl.memToReg = ctrlPkg::wbAluOut;
                endcase
            end
            default: ctrl = '0;
        endcase
    end

    pcWriteExclusive: assert property (@(posedge dec.clk)
        !(ctrl.pcWrite && ctrl.pcWriteCond));

    // one fetch per instruction, never two in a row
    irWriteFetchOnly: assert property (@(posedge dec.clk)
        ctrl.irWrite |-> (state == ctrlPkg::stFetch) ##1 !ctrl.irWrite);

endmodule

`default_nettype wire

//--- design/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

    // compare codes select the branch test in the datapath
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluEq,
        aluNe,
        aluLe,
        aluGt
    } aluOpT;

    typedef enum logic [1:0] {
        shLeft,
        shRightLogic,
        shRightArith
    } shiftOpT;

    typedef enum logic [1:0] {
        amtShamt,
        amtRs,
        amtSixteen // lui
    } shiftSrcT;

    typedef enum logic [1:0] {
        srcBReg,
        srcBFour,
        srcBImm,
        srcBBranchOffset
    } aluSrcBT;

    typedef enum logic [1:0] {
        pcAluResult,
        pcAluOut,
        pcJumpTarget
    } pcSourceT;

    typedef enum logic [1:0] {
        dstRt,
        dstRd,
        dstRa
    } regDestT;

    typedef enum logic [1:0] {
        wbAluOut,
        wbMem,
        wbShift,
        wbPcLink
    } memToRegT;

    typedef enum logic [2:0] {
        stIdle,
        stFetch,
        stDecode,
        stShiftLoad,
        stExec,
        stMemWait,
        stMemWrite,
        stWriteback
    } stateT;

    typedef struct packed {
        logic     pcWrite;
        logic     pcWriteCond;
        pcSourceT pcSource;
        logic     iorD;      // 1 selects data address
        logic     memWrite;
        logic     irWrite;
        logic     aluSrcA;   // 0 pc, 1 rs
        aluSrcBT  aluSrcB;
        aluOpT    aluOp;
        shiftSrcT shiftSrc;
        shiftOpT  shiftOp;
        regDestT  regDest;
        memToRegT memToReg;
        logic     regWrite;
    } ctrlWordT;

endpackage

`default_nettype wire

//--- design/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf (
    input logic clk
);

    isaPkg::instrClassT instrClass;
    ctrlPkg::aluOpT     aluOp;
    ctrlPkg::shiftOpT   shiftOp;
    ctrlPkg::shiftSrcT  shiftSrc;
    logic               useImm;
    logic               link;     // jal writes ra
    logic               illegal;

    modport decoder (
        output instrClass, aluOp, shiftOp, shiftSrc, useImm, link, illegal
    );

    modport sequencer (
        input instrClass, illegal
    );

    modport wordGen (
        input clk, instrClass, aluOp, shiftOp, shiftSrc, useImm, link
    );

endinterface

`default_nettype wire

//--- design/instrDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
    input isaPkg::opcodeT opcode,
    input isaPkg::functT  funct,
    decodeIf.decoder      dec
);

    always_comb
    begin
        dec.instrClass = isaPkg::clsNone;
        dec.aluOp      = ctrlPkg::aluAdd;
        dec.shiftOp    = ctrlPkg::shLeft;
        dec.shiftSrc   = ctrlPkg::amtShamt;
        dec.useImm     = 1'b0;
        dec.link       = 1'b0;
        dec.illegal    = 1'b0;

        case (opcode)
            isaPkg::opRType:
            begin
                case (funct)
                    isaPkg::fnAdd: dec.instrClass = isaPkg::clsAlu;
                    isaPkg::fnSub:
                    begin
                        dec.instrClass = isaPkg::clsAlu;
                        dec.aluOp      = ctrlPkg::aluSub;
                    end
                    isaPkg::fnAnd:
                    begin
                        dec.instrClass = isaPkg::clsAlu;
                        dec.aluOp      = ctrlPkg::aluAnd;
                    end
                    isaPkg::fnOr:
                    begin
                        dec.instrClass = isaPkg::clsAlu;
                        dec.aluOp      = ctrlPkg::aluOr;
                    end
                    isaPkg::fnSlt:
                    begin
                        dec.instrClass = isaPkg::clsAlu;
                        dec.aluOp      = ctrlPkg::aluSlt;
                    end
                    isaPkg::fnSll: dec.instrClass = isaPkg::clsShift;
                    isaPkg::fnSrl:
                    begin
                        dec.instrClass = isaPkg::clsShift;
                        dec.shiftOp    = ctrlPkg::shRightLogic;
                    end
                    isaPkg::fnSra:
                    begin
                        dec.instrClass = isaPkg::clsShift;
                        dec.shiftOp    = ctrlPkg::shRightArith;
                    end
                    isaPkg::fnSllv:
                    begin
                        dec.instrClass = isaPkg::clsShift;
                        dec.shiftSrc   = ctrlPkg::amtRs; // amount from rs
                    end
                    isaPkg::fnSrav:
                    begin
                        dec.instrClass = isaPkg::clsShift;
                        dec.shiftOp    = ctrlPkg::shRightArith;
                        dec.shiftSrc   = ctrlPkg::amtRs;
                    end
                    default: dec.illegal = 1'b1;
                endcase
            end
            isaPkg::opJ:   dec.instrClass = isaPkg::clsJump;
            isaPkg::opJal:
            begin
                dec.instrClass = isaPkg::clsJump;
                dec.link       = 1'b1;
            end
            isaPkg::opAddi, isaPkg::opAddiu:
            begin
                dec.instrClass = isaPkg::clsAlu;
                dec.useImm     = 1'b1;
            end
            isaPkg::opSlti:
            begin
                dec.instrClass = isaPkg::clsAlu;
                dec.aluOp      = ctrlPkg::aluSlt;
                dec.useImm     = 1'b1;
            end
            isaPkg::opLui:
            begin
                dec.instrClass = isaPkg::clsShift; // imm << 16 through the shifter
                dec.shiftSrc   = ctrlPkg::amtSixteen;
                dec.useImm     = 1'b1;
            end
            isaPkg::opBeq:
            begin
                dec.instrClass = isaPkg::clsBranch;
                dec.aluOp      = ctrlPkg::aluEq;
            end
            isaPkg::opBne:
            begin
                dec.instrClass = isaPkg::clsBranch;
                dec.aluOp      = ctrlPkg::aluNe;
            end
            isaPkg::opBle:
            begin
                dec.instrClass = isaPkg::clsBranch;
                dec.aluOp      = ctrlPkg::aluLe;
            end
            isaPkg::opBgt:
            begin
                dec.instrClass = isaPkg::clsBranch;
                dec.aluOp      = ctrlPkg::aluGt;
            end
            isaPkg::opLw:  dec.instrClass = isaPkg::clsLoad;
            isaPkg::opSw:  dec.instrClass = isaPkg::clsStore;
            default:       dec.illegal    = 1'b1;
        endcase

        if (dec.illegal)
        begin
            dec.instrClass = isaPkg::clsNone;
        end
    end

endmodule

`default_nettype wire

//--- design/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int opcodeWidth = 6;
    localparam int functWidth  = 6;

    typedef logic [opcodeWidth-1:0] opcodeT;
    typedef logic [functWidth-1:0]  functT;

    // primary opcodes
    localparam opcodeT opRType = 6'd0;
    localparam opcodeT opJ     = 6'd2;
    localparam opcodeT opJal   = 6'd3;
    localparam opcodeT opBeq   = 6'd4;
    localparam opcodeT opBne   = 6'd5;
    localparam opcodeT opBle   = 6'd6;
    localparam opcodeT opBgt   = 6'd7;
    localparam opcodeT opAddi  = 6'd8;
    localparam opcodeT opAddiu = 6'd9;
    localparam opcodeT opSlti  = 6'd10;
    localparam opcodeT opLui   = 6'd15;
    localparam opcodeT opLw    = 6'd35;
    localparam opcodeT opSw    = 6'd43;

    localparam functT fnSll  = 6'd0;
    localparam functT fnSrl  = 6'd2;
    localparam functT fnSra  = 6'd3;
    localparam functT fnSllv = 6'd4;
    localparam functT fnSrav = 6'd7;
    localparam functT fnAdd  = 6'd32;
    localparam functT fnSub  = 6'd34;
    localparam functT fnAnd  = 6'd36;
    localparam functT fnOr   = 6'd37;
    localparam functT fnSlt  = 6'd42;

    typedef enum logic [2:0] {
        clsAlu,
        clsShift,
        clsBranch,
        clsJump,
        clsLoad,
        clsStore,
        clsNone // illegal or unknown
    } instrClassT;

endpackage

`default_nettype wire

//--- design/stepSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stepSequencer #(
    parameter int memWaitCycles = 2
) (
    input  logic          clk,
    input  logic          arstN,
    decodeIf.sequencer    dec,
    output ctrlPkg::stateT state
);

    localparam int cntW = (memWaitCycles > 1) ? $clog2(memWaitCycles) : 1;
    localparam logic [cntW-1:0] waitLast = cntW'(memWaitCycles - 1);

    ctrlPkg::stateT  stateNext;
    logic [cntW-1:0] waitCnt;

    always_comb
    begin
        stateNext = state;
        case (state)
            ctrlPkg::stIdle:   stateNext = ctrlPkg::stFetch;
            ctrlPkg::stFetch:  stateNext = ctrlPkg::stDecode;
            ctrlPkg::stDecode:
            begin
                if (dec.illegal)
                begin
                    stateNext = ctrlPkg::stFetch; // no-op
                end
                else
                begin
                    case (dec.instrClass)
                        isaPkg::clsShift: stateNext = ctrlPkg::stShiftLoad;
                        isaPkg::clsNone:  stateNext = ctrlPkg::stFetch;
                        default:          stateNext = ctrlPkg::stExec;
                    endcase
                end
            end
            ctrlPkg::stShiftLoad: stateNext = ctrlPkg::stExec;
            ctrlPkg::stExec:
            begin
                case (dec.instrClass)
                    isaPkg::clsAlu,
                    isaPkg::clsShift: stateNext = ctrlPkg::stWriteback;
                    isaPkg::clsLoad:  stateNext = ctrlPkg::stMemWait;
                    isaPkg::clsStore: stateNext = ctrlPkg::stMemWrite;
                    default:          stateNext = ctrlPkg::stFetch; // branch, jump
                endcase
            end
            ctrlPkg::stMemWait:
            begin
                if (waitCnt == waitLast)
                begin
                    stateNext = ctrlPkg::stWriteback;
                end
            end
            ctrlPkg::stMemWrite:  stateNext = ctrlPkg::stFetch;
            ctrlPkg::stWriteback: stateNext = ctrlPkg::stFetch;
            default:              stateNext = ctrlPkg::stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state   <= ctrlPkg::stIdle;
            waitCnt <= '0;
        end
        else
        begin
            state <= stateNext;
            if (state == ctrlPkg::stMemWait)
            begin
                waitCnt <= waitCnt + 1'b1;
            end
            else
            begin
                waitCnt <= '0; // ready for next load
            end
        end
    end

    // class-specific states only for their own class
    stateMatchesClass: assert property (@(posedge clk) disable iff (!arstN)
        (state != ctrlPkg::stMemWait || dec.instrClass == isaPkg::clsLoad)
        && (state != ctrlPkg::stMemWrite || dec.instrClass == isaPkg::clsStore)
        && (state != ctrlPkg::stShiftLoad || dec.instrClass == isaPkg::clsShift));

    // a load spends exactly memWaitCycles in the wait state
    memWaitBound: assert property (@(posedge clk) disable iff (!arstN)
        (state == ctrlPkg::stExec && dec.instrClass == isaPkg::clsLoad)
        |=> ##(memWaitCycles) (state == ctrlPkg::stWriteback));

endmodule

`default_nettype wire

//--- sim.sh
#!/bin/sh
# Build and run the control unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module controlUnitTb -o controlUnitSim

./obj_dir/controlUnitSim | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation ok"
else
    echo "simulation reported failure, see sim.log"
    exit 1
fi

//--- tb.f
design/isaPkg.sv
design/ctrlPkg.sv
design/decodeIf.sv
design/instrDecoder.sv
design/stepSequencer.sv
design/controlWordGen.sv
design/controlUnit.sv
testbench/controlUnitTb.sv

//--- testbench/controlUnitTb.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitTb;

    localparam int memWait    = 2;
    localparam int numTab     = 25;
    localparam int numInstr   = 8 + 6 + 6 + 2 + numTab;
    localparam int cycleLimit = numInstr * 8 * 2;

    localparam int kAlu    = 0;
    localparam int kShift  = 1;
    localparam int kBranch = 2;
    localparam int kJump   = 3;
    localparam int kLoad   = 4;
    localparam int kStore  = 5;
    localparam int kIll    = 6;

    localparam int phFetch  = 0;
    localparam int phDecode = 1;
    localparam int phShift  = 2;
    localparam int phExec   = 3;
    localparam int phWait   = 4;
    localparam int phMemWr  = 5;
    localparam int phWb     = 6;

    logic       clk;
    logic       arstN;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic       pcWrite;
    logic       pcWriteCond;
    logic [1:0] pcSource;
    logic       iorD;
    logic       memWrite;
    logic       irWrite;
    logic       aluSrcA;
    logic [1:0] aluSrcB;
    logic [3:0] aluOp;
    logic [1:0] shiftSrc;
    logic [1:0] shiftOp;
    logic [1:0] regDest;
    logic [1:0] memToReg;
    logic       regWrite;
    logic       illegalOp;

    int     errCount;
    int     passedTests;
    int     failedTests;
    int     cycleCount = 0;
    int     curCycle;
    string  curName;
    integer seed;

    // instruction table, one entry per row
    string      nameTab  [numTab];
    logic [5:0] opTab    [numTab];
    logic [5:0] fnTab    [numTab];
    int         kindTab  [numTab];
    logic [3:0] aluTab   [numTab];
    logic [1:0] shOpTab  [numTab];
    logic [1:0] shSrcTab [numTab];

    controlUnit #(
        .memWaitCycles (memWait)
    ) DUT (
        .clk         (clk),
        .arstN       (arstN),
        .opcode      (opcode),
        .funct       (funct),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .pcSource    (pcSource),
        .iorD        (iorD),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .aluSrcA     (aluSrcA),
        .aluSrcB     (aluSrcB),
        .aluOp       (aluOp),
        .shiftSrc    (shiftSrc),
        .shiftOp     (shiftOp),
        .regDest     (regDest),
        .memToReg    (memToReg),
        .regWrite    (regWrite),
        .illegalOp   (illegalOp)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
    begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit)
        begin
            $display("ERROR: run did not finish within %0d cycles", cycleLimit);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic addInstr(input int idx, input string name, input logic [5:0] op,
                            input logic [5:0] fn, input int kind, input logic [3:0] alu);
        nameTab[idx]  = name;
        opTab[idx]    = op;
        fnTab[idx]    = fn;
        kindTab[idx]  = kind;
        aluTab[idx]   = alu;
        shOpTab[idx]  = ctrlPkg::shLeft;
        shSrcTab[idx] = ctrlPkg::amtShamt;
    endtask

    task automatic addShift(input int idx, input string name, input logic [5:0] op,
                            input logic [5:0] fn, input logic [1:0] shOp,
                            input logic [1:0] shSrc);
        addInstr(idx, name, op, fn, kShift, ctrlPkg::aluAdd);
        shOpTab[idx]  = shOp;
        shSrcTab[idx] = shSrc;
    endtask

    task automatic fillTable();
        addInstr(0, "add", isaPkg::opRType, isaPkg::fnAdd, kAlu, ctrlPkg::aluAdd);
        addInstr(1, "sub", isaPkg::opRType, isaPkg::fnSub, kAlu, ctrlPkg::aluSub);
        addInstr(2, "and", isaPkg::opRType, isaPkg::fnAnd, kAlu, ctrlPkg::aluAnd);
        addInstr(3, "or", isaPkg::opRType, isaPkg::fnOr, kAlu, ctrlPkg::aluOr);
        addInstr(4, "slt", isaPkg::opRType, isaPkg::fnSlt, kAlu, ctrlPkg::aluSlt);
        addInstr(5, "addi", isaPkg::opAddi, 6'd0, kAlu, ctrlPkg::aluAdd);
        addInstr(6, "addiu", isaPkg::opAddiu, 6'd0, kAlu, ctrlPkg::aluAdd);
        addInstr(7, "slti", isaPkg::opSlti, 6'd0, kAlu, ctrlPkg::aluSlt);
        addShift(8, "sll", isaPkg::opRType, isaPkg::fnSll, ctrlPkg::shLeft, ctrlPkg::amtShamt);
        addShift(9, "srl", isaPkg::opRType, isaPkg::fnSrl, ctrlPkg::shRightLogic,
                 ctrlPkg::amtShamt);
        addShift(10, "sra", isaPkg::opRType, isaPkg::fnSra, ctrlPkg::shRightArith,
                 ctrlPkg::amtShamt);
        addShift(11, "sllv", isaPkg::opRType, isaPkg::fnSllv, ctrlPkg::shLeft, ctrlPkg::amtRs);
        addShift(12, "srav", isaPkg::opRType, isaPkg::fnSrav, ctrlPkg::shRightArith,
                 ctrlPkg::amtRs);
        addShift(13, "lui", isaPkg::opLui, 6'd0, ctrlPkg::shLeft, ctrlPkg::amtSixteen);
        addInstr(14, "beq", isaPkg::opBeq, 6'd0, kBranch, ctrlPkg::aluEq);
        addInstr(15, "bne", isaPkg::opBne, 6'd0, kBranch, ctrlPkg::aluNe);
        addInstr(16, "ble", isaPkg::opBle, 6'd0, kBranch, ctrlPkg::aluLe);
        addInstr(17, "bgt", isaPkg::opBgt, 6'd0, kBranch, ctrlPkg::aluGt);
        addInstr(18, "j", isaPkg::opJ, 6'd0, kJump, ctrlPkg::aluAdd);
        addInstr(19, "jal", isaPkg::opJal, 6'd0, kJump, ctrlPkg::aluAdd);
        addInstr(20, "lw", isaPkg::opLw, 6'd0, kLoad, ctrlPkg::aluAdd);
        addInstr(21, "sw", isaPkg::opSw, 6'd0, kStore, ctrlPkg::aluAdd);
        addInstr(22, "bad opcode 1", 6'd1, 6'd0, kIll, ctrlPkg::aluAdd);
        addInstr(23, "bad funct 1", isaPkg::opRType, 6'd1, kIll, ctrlPkg::aluAdd);
        addInstr(24, "bad opcode 20", 6'd20, 6'd0, kIll, ctrlPkg::aluAdd);
    endtask

    function automatic int expLen(input int kind);
        case (kind)
            kAlu:           return 4;
            kShift:         return 5;
            kBranch, kJump: return 3;
            kLoad:          return 4 + memWait;
            kStore:         return 4;
            default:        return 2; // illegal is fetch and decode only
        endcase
    endfunction

    function automatic int phaseAt(input int kind, input int idx);
        if (idx == 0)
            return phFetch;
        if (idx == 1)
            return phDecode;
        case (kind)
            kShift:  return (idx == 2) ? phShift : ((idx == 3) ? phExec : phWb);
            kLoad:   return (idx == 2) ? phExec : ((idx < 3 + memWait) ? phWait : phWb);
            kStore:  return (idx == 2) ? phExec : phMemWr;
            default: return (idx == 2) ? phExec : phWb;
        endcase
    endfunction

    // order is pcWrite, pcWriteCond, memWrite, irWrite, regWrite
    function automatic logic [4:0] expWrites(input int k, input int ph);
        case (ph)
            phFetch: return 5'b10010;
            phExec:
            begin
                if (kindTab[k] == kBranch)
                    return 5'b01000;
                if (kindTab[k] == kJump)
                    return (opTab[k] == isaPkg::opJal) ? 5'b10001 : 5'b10000;
                return 5'b00000;
            end
            phMemWr: return 5'b00100;
            phWb:    return 5'b00001;
            default: return 5'b00000;
        endcase
    endfunction

    function automatic logic [1:0] expWbSrc(input int kind);
        if (kind == kShift)
            return ctrlPkg::wbShift;
        if (kind == kLoad)
            return ctrlPkg::wbMem;
        return ctrlPkg::wbAluOut;
    endfunction

    task automatic checkEq(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected)
        begin
            errCount++;
            $display("FAIL %0d ns: %s cycle %0d, %s is %0h, expected %0h",
                     $time, curName, curCycle, what, actual, expected);
        end
    endtask

    task automatic checkShifter(input int k);
        checkEq(32'(shiftOp), 32'(shOpTab[k]), "shiftOp");
        checkEq(32'(shiftSrc), 32'(shSrcTab[k]), "shiftSrc");
    endtask

    task automatic checkExec(input int k);
        logic rType;
        rType = (opTab[k] == isaPkg::opRType);
        case (kindTab[k])
            kAlu:
            begin
                checkEq(32'(aluOp), 32'(aluTab[k]), "aluOp");
                checkEq(32'(aluSrcA), 32'd1, "aluSrcA");
                checkEq(32'(aluSrcB), 32'(rType ? ctrlPkg::srcBReg : ctrlPkg::srcBImm), "aluSrcB");
            end
            kShift:  checkShifter(k);
            kBranch:
            begin
                checkEq(32'(aluOp), 32'(aluTab[k]), "compare code");
                checkEq(32'(pcSource), 32'(ctrlPkg::pcAluOut), "pcSource");
            end
            kJump:
            begin
                checkEq(32'(pcSource), 32'(ctrlPkg::pcJumpTarget), "pcSource");
                if (opTab[k] == isaPkg::opJal)
                begin
                    checkEq(32'(regDest), 32'(ctrlPkg::dstRa), "regDest");
                    checkEq(32'(memToReg), 32'(ctrlPkg::wbPcLink), "memToReg");
                end
            end
            default:
            begin
                checkEq(32'(aluOp), 32'(ctrlPkg::aluAdd), "aluOp"); // address add
                checkEq(32'(aluSrcB), 32'(ctrlPkg::srcBImm), "aluSrcB");
            end
        endcase
    endtask

    task automatic checkCycle(input int k, input int idx);
        int         ph;
        logic [4:0] writes;
        logic       rType;
        ph     = phaseAt(kindTab[k], idx);
        writes = {pcWrite, pcWriteCond, memWrite, irWrite, regWrite};
        rType  = (opTab[k] == isaPkg::opRType);
        curCycle = idx;
        checkEq(32'(writes), 32'(expWrites(k, ph)), "write enables");
        checkEq(32'(illegalOp), 32'(ph == phDecode && kindTab[k] == kIll), "illegalOp");
        case (ph)
            phFetch:
            begin
                checkEq(32'(pcSource), 32'(ctrlPkg::pcAluResult), "pcSource");
                checkEq(32'(aluSrcB), 32'(ctrlPkg::srcBFour), "aluSrcB");
                checkEq(32'(aluOp), 32'(ctrlPkg::aluAdd), "aluOp");
                checkEq(32'(iorD), 32'd0, "iorD");
            end
            phDecode: checkEq(32'(aluSrcB), 32'(ctrlPkg::srcBBranchOffset), "aluSrcB");
            phShift:  checkShifter(k);
            phExec:   checkExec(k);
            phWait:   checkEq(32'(iorD), 32'd1, "iorD");
            phMemWr:  checkEq(32'(iorD), 32'd1, "iorD");
            default:
            begin
                checkEq(32'(regDest), 32'(rType ? ctrlPkg::dstRd : ctrlPkg::dstRt), "regDest");
                checkEq(32'(memToReg), 32'(expWbSrc(kindTab[k])), "memToReg");
            end
        endcase
    endtask

    // called at a falling edge
    task automatic waitFetch();
        while (!irWrite)
            @(negedge clk);
    endtask

    task automatic runInstr(input int k);
        int idx;
        int len;
        len     = expLen(kindTab[k]);
        curName = nameTab[k];
        waitFetch();
        checkCycle(k, 0);
        @(posedge clk);
        #1;
        opcode = opTab[k]; // IR loads at this edge
        funct  = fnTab[k];
        idx = 1;
        @(negedge clk);
        while (!irWrite && idx <= len)
        begin
            if (idx < len)
                checkCycle(k, idx);
            idx++;
            @(negedge clk);
        end
        curCycle = idx;
        checkEq(32'(idx), 32'(len), "cycle count");
    endtask

    task automatic reportTest(input string testName, input int errsBefore);
        if (errCount == errsBefore)
        begin
            passedTests++;
            $display("test %s: ok", testName);
        end
        else
        begin
            failedTests++;
            $display("test %s: %0d mismatches", testName, errCount - errsBefore);
        end
    endtask

    task automatic testReset();
        int errsBefore;
        errsBefore = errCount;
        curName    = "reset";
        curCycle   = 0;
        repeat (3)
        begin
            @(negedge clk);
            checkEq(32'({pcWrite, pcWriteCond, memWrite, irWrite, regWrite}), 32'd0,
                    "writes in reset");
        end
        @(posedge clk);
        #1;
        arstN = 1'b1;
        @(negedge clk);
        checkEq(32'({pcWrite, pcWriteCond, memWrite, irWrite, regWrite}), 32'd0,
                "writes after release");
        @(negedge clk);
        checkEq(32'(irWrite), 32'd1, "irWrite");
        checkEq(32'(pcWrite), 32'd1, "pcWrite");
        checkEq(32'(pcSource), 32'(ctrlPkg::pcAluResult), "pcSource");
        checkEq(32'(aluSrcB), 32'(ctrlPkg::srcBFour), "aluSrcB");
        reportTest("reset", errsBefore);
    endtask

    task automatic runGroup(input string testName, input int first, input int last);
        int errsBefore;
        errsBefore = errCount;
        for (int k = first; k <= last; k++)
            runInstr(k);
        reportTest(testName, errsBefore);
    endtask

    task automatic testRandomMix();
        int order [numTab];
        int j;
        int tmp;
        int errsBefore;
        errsBefore = errCount;
        for (int i = 0; i < numTab; i++)
            order[i] = i;
        for (int i = numTab - 1; i > 0; i--)
        begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < numTab; i++)
            runInstr(order[i]);
        reportTest("illegal and random mix", errsBefore);
    endtask

    initial
    begin
        seed        = 32'h1e8d_05c5;
        errCount    = 0;
        passedTests = 0;
        failedTests = 0;
        curCycle    = 0;
        clk         = 1'b0;
        arstN       = 1'b0;
        opcode      = isaPkg::opRType;
        funct       = isaPkg::fnAdd;
        fillTable();

        testReset();
        runGroup("alu", 0, 7);
        runGroup("shift and lui", 8, 13);
        runGroup("branch and jump", 14, 19);
        runGroup("load and store", 20, 21);
        testRandomMix();

        $display("tests passed %0d, failed %0d, mismatches %0d",
                 passedTests, failedTests, errCount);
        if (errCount == 0)
        begin
            $display("*** TEST PASSED ***");
        end
        else
        begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
